/* bench/decodeRef.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

`default_nettype none

// expected decode results, straight from the RV32I decode rules

function automatic logic refIllegal(input logic [31:0] i);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = i[14:12];
    f7 = i[31:25];
    case (i[6:0])
        rvDecodePkg::OpR:      return (f7 != 7'h00 && f7 != 7'h20)
                                   || (f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5);
        rvDecodePkg::OpImm:    return (f3 == 3'd1 && f7 != 7'h00)
                                   || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        rvDecodePkg::OpLoad:   return f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7;
        rvDecodePkg::OpStore:  return f3 > 3'd2;
        rvDecodePkg::OpBranch: return f3 == 3'd2 || f3 == 3'd3;
        rvDecodePkg::OpJalr:   return f3 != 3'd0;
        rvDecodePkg::OpJal, rvDecodePkg::OpLui, rvDecodePkg::OpAuipc,
        rvDecodePkg::OpFence, rvDecodePkg::OpSystem: return 1'b0;
        default:               return 1'b1;
    endcase
endfunction

function automatic logic [31:0] refImm(input logic [31:0] i);
    logic [31:0] v;
    case (i[6:0])
        rvDecodePkg::OpImm:
            if (i[14:12] == 3'd1 || i[14:12] == 3'd5) v = {27'd0, i[24:20]};
            else v = {{20{i[31]}}, i[31:20]};
        rvDecodePkg::OpLoad, rvDecodePkg::OpJalr: v = {{20{i[31]}}, i[31:20]};
        rvDecodePkg::OpStore:  v = {{20{i[31]}}, i[31:25], i[11:7]};
        rvDecodePkg::OpBranch: v = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        rvDecodePkg::OpLui, rvDecodePkg::OpAuipc: v = {i[31:12], 12'h000};
        rvDecodePkg::OpJal:    v = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        default:               v = 32'd0;
    endcase
    return refIllegal(i) ? 32'd0 : v;
endfunction

function automatic rvDecodePkg::ctrlWordT refCtrl(input logic [31:0] i);
    rvDecodePkg::ctrlWordT c;
    rvDecodePkg::aluOpE    byF3;
    c = '0;
    case (i[14:12])
        3'd0: byF3 = rvDecodePkg::AluAdd;
        3'd1: byF3 = rvDecodePkg::AluSll;
        3'd2: byF3 = rvDecodePkg::AluSlt;
        3'd3: byF3 = rvDecodePkg::AluSltu;
        3'd4: byF3 = rvDecodePkg::AluXor;
        3'd5: byF3 = (i[31:25] == 7'h20) ? rvDecodePkg::AluSra : rvDecodePkg::AluSrl;
        3'd6: byF3 = rvDecodePkg::AluOr;
        default: byF3 = rvDecodePkg::AluAnd;
    endcase
    case (i[6:0])
        rvDecodePkg::OpR: begin
            c.aluOp = (i[14:12] == 3'd0 && i[31:25] == 7'h20) ? rvDecodePkg::AluSub : byF3;
            c.regWrite = 1'b1;
        end
        rvDecodePkg::OpImm: begin
            c.aluOp = byF3;
            c.srcBSel = rvDecodePkg::SrcBImm;
            c.regWrite = 1'b1;
        end
        rvDecodePkg::OpLoad: begin
            c.srcBSel = rvDecodePkg::SrcBImm;
            c.loadExt = i[14:12];
            c.memRead = 1'b1;
            c.regWrite = 1'b1;
            c.memToReg = 1'b1;
        end
        rvDecodePkg::OpStore: begin
            c.srcBSel = rvDecodePkg::SrcBImm;
            c.memWrite = 1'b1;
        end
        rvDecodePkg::OpBranch: begin
            c.aluOp = rvDecodePkg::AluSub;
            c.branch = 1'b1;
        end
        rvDecodePkg::OpJal, rvDecodePkg::OpJalr, rvDecodePkg::OpAuipc: begin
            c.srcASel = (i[6:0] == rvDecodePkg::OpJalr) ? rvDecodePkg::SrcAReg
                                                         : rvDecodePkg::SrcAPc;
            c.srcBSel = rvDecodePkg::SrcBImm;
            c.jump = i[6:0] != rvDecodePkg::OpAuipc;
            c.regWrite = 1'b1;
        end
        rvDecodePkg::OpLui: begin
            c.aluOp = rvDecodePkg::AluPassB;
            c.srcBSel = rvDecodePkg::SrcBImm;
            c.regWrite = 1'b1;
        end
        default: c = '0;   // fence, system, unknown
    endcase
    return refIllegal(i) ? rvDecodePkg::ctrlWordT'('0) : c;
endfunction

`default_nettype wire

`endif

/* bench/decodeTb.sv */
`default_nettype none

module decodeTb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "decodeRef.svh"

    localparam int totalInstr = 240;   // upper bound over all tests
    localparam int numRandom  = 150;

    logic        clk = 1'b0;
    logic        arstN;
    logic        inValid;
    logic [31:0] inInstr;
    logic [31:0] inPc;
    logic        inReady;
    logic        outValid;
    logic        outReady;
    logic [3:0]  outAluOp;
    logic        outSrcASel;
    logic        outSrcBSel;
    logic [2:0]  outLoadExt;
    logic        outMemRead, outMemWrite, outRegWrite, outMemToReg, outBranch, outJump;
    logic [31:0] outImm;
    logic [4:0]  outRd, outRs1, outRs2;
    logic        outIllegal;
    logic [31:0] outPc;

    integer      seed = 32'h5f46;
    int          errCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          testStartErr;
    int          cycle = 0;
    int          readyMode = 0;   // 0 high, 1 low, 2 random
    bit          sawFull = 1'b0;
    logic [31:0] expInstr[$];
    logic [31:0] expPc[$];
    logic [31:0] frontInstr = 32'd0;
    logic [31:0] frontPc = 32'd0;
    rvDecodePkg::ctrlWordT expCtrl;

    decodeTop decodeTop_inst (
        .clk(clk), .arstN(arstN), .inValid(inValid), .inInstr(inInstr), .inPc(inPc),
        .inReady(inReady), .outValid(outValid), .outReady(outReady),
        .outAluOp(outAluOp), .outSrcASel(outSrcASel), .outSrcBSel(outSrcBSel),
        .outLoadExt(outLoadExt), .outMemRead(outMemRead), .outMemWrite(outMemWrite),
        .outRegWrite(outRegWrite), .outMemToReg(outMemToReg), .outBranch(outBranch),
        .outJump(outJump), .outImm(outImm), .outRd(outRd), .outRs1(outRs1),
        .outRs2(outRs2), .outIllegal(outIllegal), .outPc(outPc)
    );

    always #5 clk = ~clk;

    assign expCtrl = refCtrl(frontInstr);

    // expected queue bookkeeping, front valid for the next output transfer
    always @(posedge clk) begin
        cycle++;
        if (inValid && !inReady) sawFull = 1'b1;
        if (outValid && outReady && expInstr.size() != 0) begin
            void'(expInstr.pop_front());
            void'(expPc.pop_front());
        end
        if (inValid && inReady) begin
            expInstr.push_back(inInstr);
            expPc.push_back(inPc);
        end
        frontInstr <= (expInstr.size() != 0) ? expInstr[0] : 32'd0;
        frontPc    <= (expPc.size() != 0) ? expPc[0] : 32'd0;
    end

    always @(negedge clk) begin
        case (readyMode)
            0:       outReady = 1'b1;
            1:       outReady = 1'b0;
            default: outReady = $random(seed) & 1;
        endcase
    end

    task automatic logError(input string msg);
        errCount++;
        $display("%s", msg);
    endtask

    resetState: assert property (@(posedge clk) !arstN |-> !outValid && inReady)
        else logError($sformatf("ERROR outValid/inReady in reset expected %h actual %h",
            2'b01, $sampled({outValid, inReady})));
    noPhantom: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> expInstr.size() != 0)
        else logError("output valid with no instruction outstanding");

    chkAluOp: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outAluOp == expCtrl.aluOp)
        else logError($sformatf("ERROR outAluOp expected %h actual %h",
            $sampled(expCtrl.aluOp), $sampled(outAluOp)));
    chkSrcA: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outSrcASel == expCtrl.srcASel)
        else logError($sformatf("ERROR outSrcASel expected %h actual %h",
            $sampled(expCtrl.srcASel), $sampled(outSrcASel)));
    chkSrcB: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outSrcBSel == expCtrl.srcBSel)
        else logError($sformatf("ERROR outSrcBSel expected %h actual %h",
            $sampled(expCtrl.srcBSel), $sampled(outSrcBSel)));
    chkLoadExt: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outLoadExt == expCtrl.loadExt)
        else logError($sformatf("ERROR outLoadExt expected %h actual %h",
            $sampled(expCtrl.loadExt), $sampled(outLoadExt)));
    chkFlags: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> {outMemRead, outMemWrite, outRegWrite, outMemToReg,
        outBranch, outJump} == {expCtrl.memRead, expCtrl.memWrite, expCtrl.regWrite,
        expCtrl.memToReg, expCtrl.branch, expCtrl.jump})
        else logError($sformatf("ERROR outMemRead..outJump expected %h actual %h",
            $sampled(expCtrl[5:0]), $sampled({outMemRead, outMemWrite, outRegWrite,
            outMemToReg, outBranch, outJump})));
    chkImm: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outImm == refImm(frontInstr))
        else logError($sformatf("ERROR outImm expected %h actual %h",
            refImm($sampled(frontInstr)), $sampled(outImm)));
    chkIllegal: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outIllegal == refIllegal(frontInstr))
        else logError($sformatf("ERROR outIllegal expected %h actual %h",
            refIllegal($sampled(frontInstr)), $sampled(outIllegal)));
    chkRegs: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> {outRd, outRs1, outRs2} ==
        {frontInstr[11:7], frontInstr[19:15], frontInstr[24:20]})
        else logError($sformatf("ERROR outRd/outRs1/outRs2 expected %h actual %h",
            {$sampled(frontInstr[11:7]), $sampled(frontInstr[19:15]),
            $sampled(frontInstr[24:20])}, $sampled({outRd, outRs1, outRs2})));
    chkPc: assert property (@(posedge clk) disable iff (!arstN)
        outValid && outReady |-> outPc == frontPc)
        else logError($sformatf("ERROR outPc expected %h actual %h",
            $sampled(frontPc), $sampled(outPc)));

    function automatic logic [31:0] mkInstr(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] randInstr();
        logic [31:0] r;
        logic [6:0]  op;
        logic [6:0]  f7;
        r = $random(seed);
        case ($unsigned($random(seed)) % 12)
            0: op = rvDecodePkg::OpR;
            1: op = rvDecodePkg::OpImm;
            2: op = rvDecodePkg::OpLoad;
            3: op = rvDecodePkg::OpStore;
            4: op = rvDecodePkg::OpBranch;
            5: op = rvDecodePkg::OpJal;
            6: op = rvDecodePkg::OpJalr;
            7: op = rvDecodePkg::OpLui;
            8: op = rvDecodePkg::OpAuipc;
            9: op = rvDecodePkg::OpFence;
            10: op = rvDecodePkg::OpSystem;
            default: op = r[6:0];   // mostly unknown opcodes
        endcase
        case ($unsigned($random(seed)) % 3)
            0: f7 = 7'h00;
            1: f7 = 7'h20;
            default: f7 = r[31:25];
        endcase
        return {f7, r[24:7], op};
    endfunction

    task automatic sendInstr(input logic [31:0] instr, input logic [31:0] pc);
        @(negedge clk);
        inValid = 1'b1;
        inInstr = instr;
        inPc    = pc;
        while (!inReady) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic stopInput();
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        stopInput();
        while (expInstr.size() != 0 || outValid) @(negedge clk);
    endtask

    task automatic startTest();
        testStartErr = errCount;
    endtask

    task automatic finishTest(input string name);
        if (errCount == testStartErr) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: fail, %0d errors", name, errCount - testStartErr);
        end
    endtask

    initial begin
        repeat (totalInstr * 20 + 200) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int f3;
        int acceptCycle;
        arstN   = 1'b0;
        inValid = 1'b0;
        inInstr = 32'd0;
        inPc    = 32'd0;
        outReady = 1'b1;

        startTest();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        if (outValid || !inReady) begin
            logError($sformatf("ERROR outValid/inReady after reset expected %h actual %h",
                2'b01, {outValid, inReady}));
        end
        finishTest("reset");

        startTest();
        sendInstr(32'hfff10093, 32'h100);   // addi -1
        sendInstr(32'h7ff10093, 32'h104);   // addi 2047
        sendInstr(32'h01f21193, 32'h108);   // slli 31
        sendInstr(32'h40725193, 32'h10c);   // srai 7
        sendInstr(32'hfe532e23, 32'h110);   // sw negative
        sendInstr(32'h00532423, 32'h114);
        sendInstr(32'hfe208ce3, 32'h118);   // beq back
        sendInstr(32'h00209863, 32'h11c);
        sendInstr(32'hfffff3b7, 32'h120);   // lui
        sendInstr(32'h12345397, 32'h124);   // auipc
        sendInstr(32'h800000ef, 32'h128);   // jal negative
        sendInstr(32'h7fdff0ef, 32'h12c);
        waitDrain();
        finishTest("immediates");

        startTest();
        for (f3 = 0; f3 < 8; f3++) begin
            sendInstr(mkInstr(7'h00, 5'(f3 + 1), 5'(f3 + 2), 3'(f3), 5'(f3 + 3),
                rvDecodePkg::OpR), 32'h200 + f3 * 4);
            sendInstr(mkInstr(7'h20, 5'd9, 5'd10, 3'(f3), 5'd11, rvDecodePkg::OpR),
                32'h300 + f3 * 4);
            sendInstr(mkInstr(7'h00, 5'd3, 5'd4, 3'(f3), 5'd5, rvDecodePkg::OpImm),
                32'h400 + f3 * 4);
            sendInstr(mkInstr(7'h20, 5'd3, 5'd4, 3'(f3), 5'd5, rvDecodePkg::OpImm),
                32'h500 + f3 * 4);
            sendInstr(mkInstr(7'h01, 5'd6, 5'd7, 3'(f3), 5'd8, rvDecodePkg::OpLoad),
                32'h600 + f3 * 4);
            sendInstr(mkInstr(7'h7f, 5'd6, 5'd7, 3'(f3), 5'd8, rvDecodePkg::OpStore),
                32'h700 + f3 * 4);
            sendInstr(mkInstr(7'h3f, 5'd1, 5'd2, 3'(f3), 5'd3, rvDecodePkg::OpBranch),
                32'h800 + f3 * 4);
            sendInstr(mkInstr(7'h00, 5'd1, 5'd2, 3'(f3), 5'd3, rvDecodePkg::OpJalr),
                32'h900 + f3 * 4);
        end
        sendInstr(mkInstr(7'h12, 5'd1, 5'd2, 3'd5, 5'd3, rvDecodePkg::OpJal), 32'ha00);
        sendInstr(mkInstr(7'h55, 5'd1, 5'd2, 3'd1, 5'd31, rvDecodePkg::OpLui), 32'ha04);
        sendInstr(mkInstr(7'h2a, 5'd1, 5'd2, 3'd6, 5'd30, rvDecodePkg::OpAuipc), 32'ha08);
        waitDrain();
        finishTest("control word");

        startTest();
        sendInstr(mkInstr(7'h01, 5'd1, 5'd2, 3'd0, 5'd3, rvDecodePkg::OpR), 32'hb00);
        sendInstr(mkInstr(7'h20, 5'd1, 5'd2, 3'd1, 5'd3, rvDecodePkg::OpImm), 32'hb04);
        sendInstr(mkInstr(7'h10, 5'd1, 5'd2, 3'd5, 5'd3, rvDecodePkg::OpImm), 32'hb08);
        sendInstr(32'hffffffff, 32'hb0c);   // unknown opcode
        sendInstr(32'h0000007b, 32'hb10);
        sendInstr(32'h0ff0000f, 32'hb14);   // fence
        sendInstr(32'h00000073, 32'hb18);   // ecall
        sendInstr(32'h00100073, 32'hb1c);   // ebreak
        waitDrain();
        finishTest("illegal encodings");

        startTest();
        sendInstr(32'h00510093, 32'hc00);
        stopInput();
        acceptCycle = cycle - 1;   // count during the accepting cycle
        while (!outValid && cycle < acceptCycle + 10) @(negedge clk);
        if (cycle - acceptCycle != 2) begin
            errCount++;
            $display("first result took %0d cycles instead of 2", cycle - acceptCycle);
        end
        waitDrain();
        readyMode = 1;
        sawFull = 1'b0;
        fork
            begin
                repeat (12) @(negedge clk);
                readyMode = 2;
            end
            begin
                for (int n = 0; n < numRandom; n++) begin
                    sendInstr(randInstr(), $random(seed));
                end
            end
        join
        waitDrain();
        readyMode = 0;
        if (!sawFull) begin
            errCount++;
            $display("inReady never dropped while the queue was stalled");
        end
        finishTest("back-pressure");

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/decodeBusIf.sv */
`default_nettype none

// one decoded instruction, decoder to output register
interface decodeBusIf;
    logic                  valid;
    logic                  ready;
    rvDecodePkg::ctrlWordT ctrl;
    logic [31:0]           imm;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic                  illegal;
    logic [31:0]           pc;

    modport src (
        output valid, ctrl, imm, rd, rs1, rs2, illegal, pc,
        input  ready
    );

    modport dst (
        input  valid, ctrl, imm, rd, rs1, rs2, illegal, pc,
        output ready
    );
endinterface

`default_nettype wire

/* design/decodeOutReg.sv */
`default_nettype none

module decodeOutReg (
    input  wire                    clk,
    input  wire                    arstN,
    decodeBusIf.dst                result,
    output logic                   outValid,
    input  wire                    outReady,
    output rvDecodePkg::ctrlWordT  outCtrl,
    output logic [31:0]            outImm,
    output logic [4:0]             outRd,
    output logic [4:0]             outRs1,
    output logic [4:0]             outRs2,
    output logic                   outIllegal,
    output logic [31:0]            outPc
);
    logic load;

    // take a new item when empty or draining this cycle
    assign result.ready = !outValid || outReady;
    assign load         = result.valid && result.ready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (result.ready) begin
            outValid <= result.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outCtrl    <= result.ctrl;
            outImm     <= result.imm;
            outRd      <= result.rd;
            outRs1     <= result.rs1;
            outRs2     <= result.rs2;
            outIllegal <= result.illegal;
            outPc      <= result.pc;
        end
    end

    // stalled item must not change under the consumer
    holdStable: assert property (
        @(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outCtrl) && $stable(outImm)
            && $stable(outRd) && $stable(outRs1) && $stable(outRs2)
            && $stable(outIllegal) && $stable(outPc)
    ) else $error("decodeOutReg output changed while stalled");

endmodule

`default_nettype wire

/* design/decodeTop.sv */
`default_nettype none

module decodeTop (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   inValid,
    input  wire  [31:0]           inInstr,
    input  wire  [31:0]           inPc,
    output logic                  inReady,
    output logic                  outValid,
    input  wire                   outReady,
    output rvDecodePkg::aluOpE    outAluOp,
    output rvDecodePkg::srcASelE  outSrcASel,
    output rvDecodePkg::srcBSelE  outSrcBSel,
    output logic [2:0]            outLoadExt,
    output logic                  outMemRead,
    output logic                  outMemWrite,
    output logic                  outRegWrite,
    output logic                  outMemToReg,
    output logic                  outBranch,
    output logic                  outJump,
    output logic [31:0]           outImm,
    output logic [4:0]            outRd,
    output logic [4:0]            outRs1,
    output logic [4:0]            outRs2,
    output logic                  outIllegal,
    output logic [31:0]           outPc
);
    localparam int QUEUE_DEPTH = 4;

    rvDecodePkg::ctrlWordT outCtrl;

    instrStreamIf streamBus ();
    decodeBusIf   resultBus ();

    instrQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) instrQueue_inst (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .inInstr (inInstr),
        .inPc    (inPc),
        .inReady (inReady),
        .stream  (streamBus.src)
    );

    instrDecoder instrDecoder_inst (
        .stream (streamBus.dst),
        .result (resultBus.src)
    );

    decodeOutReg decodeOutReg_inst (
        .clk        (clk),
        .arstN      (arstN),
        .result     (resultBus.dst),
        .outValid   (outValid),
        .outReady   (outReady),
        .outCtrl    (outCtrl),
        .outImm     (outImm),
        .outRd      (outRd),
        .outRs1     (outRs1),
        .outRs2     (outRs2),
        .outIllegal (outIllegal),
        .outPc      (outPc)
    );

    // control word fields onto flat ports
    assign outAluOp    = outCtrl.aluOp;
    assign outSrcASel  = outCtrl.srcASel;
    assign outSrcBSel  = outCtrl.srcBSel;
    assign outLoadExt  = outCtrl.loadExt;
    assign outMemRead  = outCtrl.memRead;
    assign outMemWrite = outCtrl.memWrite;
    assign outRegWrite = outCtrl.regWrite;
    assign outMemToReg = outCtrl.memToReg;
    assign outBranch   = outCtrl.branch;
    assign outJump     = outCtrl.jump;

endmodule

`default_nettype wire

/* design/immGen.sv */
`default_nettype none

module immGen (
    input  wire  [31:0] instr,
    output logic [31:0] imm
);
    rvDecodePkg::opcodeE opcode;
    logic [2:0]          funct3;
    logic                isShiftImm;

    assign opcode     = rvDecodePkg::opcodeE'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign isShiftImm = (funct3 == 3'd1) || (funct3 == 3'd5);   // slli, srli, srai

    always_comb begin
        case (opcode)
            rvDecodePkg::OpImm: begin
                if (isShiftImm) begin
                    imm = {27'd0, instr[24:20]};   // shamt only
                end else begin
                    imm = {{21{instr[31]}}, instr[30:20]};
                end
            end
            rvDecodePkg::OpLoad,
            rvDecodePkg::OpJalr: begin
                imm = {{21{instr[31]}}, instr[30:20]};
            end
            rvDecodePkg::OpStore: begin
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            end
            rvDecodePkg::OpBranch: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvDecodePkg::OpLui,
            rvDecodePkg::OpAuipc: begin
                imm = {instr[31:12], 12'd0};
            end
            rvDecodePkg::OpJal: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = 32'd0;   // R, fence, system, unknown
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`default_nettype none

module instrDecoder (
    instrStreamIf.dst stream,
    decodeBusIf.src   result
);
    logic [31:0]           instr;
    rvDecodePkg::opcodeE   opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [31:0]           rawImm;
    rvDecodePkg::aluOpE    funct3Op;
    rvDecodePkg::ctrlWordT ctrl;
    logic                  illegal;

    assign instr  = stream.instr;
    assign opcode = rvDecodePkg::opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    immGen immGen_inst (
        .instr (instr),
        .imm   (rawImm)
    );

    // funct3 mapping common to OpR and OpImm
    always_comb begin
        case (funct3)
            3'd0:    funct3Op = rvDecodePkg::AluAdd;
            3'd1:    funct3Op = rvDecodePkg::AluSll;
            3'd2:    funct3Op = rvDecodePkg::AluSlt;
            3'd3:    funct3Op = rvDecodePkg::AluSltu;
            3'd4:    funct3Op = rvDecodePkg::AluXor;
            3'd5:    funct3Op = rvDecodePkg::AluSrl;
            3'd6:    funct3Op = rvDecodePkg::AluOr;
            default: funct3Op = rvDecodePkg::AluAnd;
        endcase
    end

    always_comb begin
        ctrl    = '0;   // add, reg/reg, nothing enabled
        illegal = 1'b0;
        case (opcode)
            rvDecodePkg::OpR: begin
                ctrl.aluOp    = funct3Op;
                ctrl.regWrite = 1'b1;
                if (funct7 == 7'h20) begin
                    if (funct3 == 3'd0) begin
                        ctrl.aluOp = rvDecodePkg::AluSub;
                    end else if (funct3 == 3'd5) begin
                        ctrl.aluOp = rvDecodePkg::AluSra;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 != 7'h00) begin
                    illegal = 1'b1;
                end
            end
            rvDecodePkg::OpImm: begin
                ctrl.aluOp    = funct3Op;
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.regWrite = 1'b1;
                if (funct3 == 3'd1 && funct7 != 7'h00) begin
                    illegal = 1'b1;
                end
                if (funct3 == 3'd5) begin
                    if (funct7 == 7'h20) begin
                        ctrl.aluOp = rvDecodePkg::AluSra;
                    end else if (funct7 != 7'h00) begin
                        illegal = 1'b1;
                    end
                end
            end
            rvDecodePkg::OpLoad: begin
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.loadExt  = funct3;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                illegal       = (funct3 == 3'd3) || (funct3 > 3'd5);   // no ld, lwu
            end
            rvDecodePkg::OpStore: begin
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.memWrite = 1'b1;
                illegal       = funct3 > 3'd2;
            end
            rvDecodePkg::OpBranch: begin
                ctrl.aluOp  = rvDecodePkg::AluSub;   // compare by subtract
                ctrl.branch = 1'b1;
                illegal     = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            rvDecodePkg::OpJal: begin
                ctrl.srcASel  = rvDecodePkg::SrcAPc;
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            rvDecodePkg::OpJalr: begin
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                illegal       = funct3 != 3'd0;
            end
            rvDecodePkg::OpLui: begin
                ctrl.aluOp    = rvDecodePkg::AluPassB;
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.regWrite = 1'b1;
            end
            rvDecodePkg::OpAuipc: begin
                ctrl.srcASel  = rvDecodePkg::SrcAPc;
                ctrl.srcBSel  = rvDecodePkg::SrcBImm;
                ctrl.regWrite = 1'b1;
            end
            rvDecodePkg::OpFence,
            rvDecodePkg::OpSystem: begin
                ctrl = '0;   // treated as nop here
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    assign stream.ready   = result.ready;
    assign result.valid   = stream.valid;
    assign result.ctrl    = illegal ? '0 : ctrl;
    assign result.imm     = illegal ? 32'd0 : rawImm;
    assign result.illegal = illegal;
    assign result.rd      = instr[11:7];
    assign result.rs1     = instr[19:15];
    assign result.rs2     = instr[24:20];
    assign result.pc      = stream.pc;

endmodule

`default_nettype wire

/* design/instrQueue.sv */
`default_nettype none

module instrQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire         clk,
    input  wire         arstN,
    input  wire         inValid,
    input  wire  [31:0] inInstr,
    input  wire  [31:0] inPc,
    output logic        inReady,
    instrStreamIf.src   stream
);
    localparam int ptrWidth = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cntWidth = $clog2(QUEUE_DEPTH + 1);

    logic [31:0] instrMem [QUEUE_DEPTH];
    logic [31:0] pcMem    [QUEUE_DEPTH];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                push;
    logic                pop;

    assign inReady = count < cntWidth'(QUEUE_DEPTH);
    assign push    = inValid && inReady;
    assign pop     = stream.valid && stream.ready;

    assign stream.valid = count != '0;
    assign stream.instr = instrMem[rdPtr];
    assign stream.pc    = pcMem[rdPtr];

    // storage only, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            instrMem[wrPtr] <= inInstr;
            pcMem[wrPtr]    <= inPc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                // depth need not be a power of two
                wrPtr <= (wrPtr == ptrWidth'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push with pop
            endcase
        end
    end

    countBound: assert property (
        @(posedge clk) disable iff (!arstN) count <= cntWidth'(QUEUE_DEPTH)
    ) else $error("instrQueue count %0d above depth %0d", count, QUEUE_DEPTH);

endmodule

`default_nettype wire

/* design/instrStreamIf.sv */
`default_nettype none

// fetched instruction with its pc, queue head to decoder
interface instrStreamIf;
    logic        valid;
    logic        ready;
    logic [31:0] instr;
    logic [31:0] pc;

    modport src (
        output valid,
        output instr,
        output pc,
        input  ready
    );

    modport dst (
        input  valid,
        input  instr,
        input  pc,
        output ready
    );
endinterface

`default_nettype wire

/* design/rvDecodePkg.sv */
`default_nettype none

package rvDecodePkg;

    // RV32I major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OpR      = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpFence  = 7'b0001111,
        OpSystem = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluSll   = 4'd2,
        AluSlt   = 4'd3,
        AluSltu  = 4'd4,
        AluXor   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluOr    = 4'd8,
        AluAnd   = 4'd9,
        AluPassB = 4'd10   // lui result is the immediate
    } aluOpE;

    typedef enum logic {
        SrcAReg = 1'b0,
        SrcAPc  = 1'b1
    } srcASelE;

    typedef enum logic {
        SrcBReg = 1'b0,
        SrcBImm = 1'b1
    } srcBSelE;

    // execute stage control, msb first
    typedef struct packed {
        aluOpE      aluOp;
        srcASelE    srcASel;
        srcBSelE    srcBSel;
        logic [2:0] loadExt;   // load funct3, width and sign
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic       memToReg;
        logic       branch;
        logic       jump;
    } ctrlWordT;

endpackage

`default_nettype wire

/* files.f */
+incdir+bench
design/rvDecodePkg.sv
design/instrStreamIf.sv
design/decodeBusIf.sv
design/instrQueue.sv
design/immGen.sv
design/instrDecoder.sv
design/decodeOutReg.sv
design/decodeTop.sv
bench/decodeTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module decodeTb -f files.f -o simDecode

output=$(./obj_dir/simDecode)
echo "$output"
echo "$output" | grep -q "^Test OK$"
